//--- all.f
+incdir+.
corr_pkg.sv
lag_ram.sv
cic_decimator.sv
sample_history.sv
lag_correlator.sv
integration_ctrl.sv
correlator_top.sv
tb_correlator.sv

//--- cic_decimator.sv
////////////////////////////////////////////////////////////////////////////
// Five-stage CIC decimator for one PDM microphone
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "corr_config.svh"

module cic_decimator
  import corr_pkg::*;
#(
  parameter int DECIM_RATIO = `DECIM
) (
  input  logic    clk_in,
  input  logic    i_rst,
  input  logic    i_pdm_valid,
  input  logic    i_pdm_bit,
  output logic    o_sample_valid,
  output sample_t o_sample
);

  localparam int CNT_W = (DECIM_RATIO > 1) ? $clog2(DECIM_RATIO) : 1;
  localparam logic signed [`CIC_W-1:0] PDM_POS = 1;
  localparam logic signed [`CIC_W-1:0] PDM_NEG = -1;

  logic signed [`CIC_W-1:0] integ     [5];
  logic signed [`CIC_W-1:0] integ_nxt [5];
  // Previous decimated input of each comb stage
  logic signed [`CIC_W-1:0] comb_dly  [5];
  // comb_val[0] feeds the first comb, comb_val[5] is the filter output
  logic signed [`CIC_W-1:0] comb_val  [6];
  logic [CNT_W-1:0]         dec_cnt;
  logic                     dec_fire;

  always_comb begin
    // PDM 1 is +1, PDM 0 is -1
    integ_nxt[0] = integ[0] + (i_pdm_bit ? PDM_POS : PDM_NEG);
    // Each integrator adds the fresh value of the stage before
    for (int k = 1; k < 5; k++) begin
      integ_nxt[k] = integ[k] + integ_nxt[k-1];
    end
    comb_val[0] = integ_nxt[4];
    for (int c = 0; c < 5; c++) begin
      comb_val[c+1] = comb_val[c] - comb_dly[c];
    end
  end

  // Last strobe of the decimation window
  assign dec_fire = i_pdm_valid && (dec_cnt == CNT_W'(DECIM_RATIO - 1));

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      for (int k = 0; k < 5; k++) begin
        integ[k]    <= '0;
        comb_dly[k] <= '0;
      end
      dec_cnt        <= '0;
      o_sample_valid <= 1'b0;
    end else begin
      o_sample_valid <= dec_fire;
      if (i_pdm_valid) begin
        integ   <= integ_nxt;
        dec_cnt <= dec_fire ? '0 : dec_cnt + 1'b1;
      end
      if (dec_fire) begin
        for (int c = 0; c < 5; c++) begin
          comb_dly[c] <= comb_val[c];
        end
      end
    end
  end

  // Scaled comb output, narrowed to the sample width
  always_ff @(posedge clk_in) begin
    if (dec_fire) begin
      o_sample <= sample_t'(comb_val[5] >>> `CIC_SHIFT);
    end
  end

  // Source must leave at least one idle cycle between strobes
  a_strobe_gap: assert property (@(posedge clk_in) disable iff (i_rst)
    i_pdm_valid |=> !i_pdm_valid);

endmodule

//--- corr_config.svh
////////////////////////////////////////////////////////////////////////////
// Array size, CIC filter and accumulator width defines for the
// microphone-array lag correlator
////////////////////////////////////////////////////////////////////////////
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// Microphones in the array
`define NUM_MICS 3
// Lags per baseline, a power of two so the history pointer wraps cleanly
`define NUM_LAGS 8
// One baseline for every pair i<j
`define NUM_BASELINES (`NUM_MICS * (`NUM_MICS - 1) / 2)

// PDM strobes per audio sample
`define DECIM 16
// CIC register width, all stages wrap at this width
`define CIC_W 32
// Gain is DECIM**5, the shift brings it back into the sample range
`define CIC_SHIFT 4

// Audio sample and lag accumulator widths
`define SAMPLE_W 18
`define ACC_W 48

// Samples summed before the accumulators are read out
`define INTEG_SAMPLES 4

`endif

//--- corr_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Sample, accumulator, lag index and baseline index types
////////////////////////////////////////////////////////////////////////////
`include "corr_config.svh"

package corr_pkg;

  // Index widths, at least one bit each
  localparam int LAG_IDX_W = (`NUM_LAGS > 1) ? $clog2(`NUM_LAGS) : 1;
  localparam int BL_IDX_W  = (`NUM_BASELINES > 1) ? $clog2(`NUM_BASELINES) : 1;

  // Decimated audio sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;
  // Sum of products for one lag
  typedef logic signed [`ACC_W-1:0]    acc_t;
  typedef logic [LAG_IDX_W-1:0]        lag_idx_t;
  typedef logic [BL_IDX_W-1:0]         bl_idx_t;

endpackage

//--- correlator_top.sv
////////////////////////////////////////////////////////////////////////////
// Lag correlator top, decimators, histories, baselines and export control
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "corr_config.svh"

module correlator_top
  import corr_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 i_rst,
  input  logic                 i_pdm_valid,
  input  logic [`NUM_MICS-1:0] i_pdm_bits,
  output logic                 o_acc_valid,
  output bl_idx_t              o_acc_bl,
  output lag_idx_t             o_acc_lag,
  output acc_t                 o_acc_data,
  output logic                 o_acc_last
);

  // Per microphone
  logic     dec_valid  [`NUM_MICS];
  sample_t  dec_sample [`NUM_MICS];
  sample_t  cur_sample [`NUM_MICS];
  logic     lag_valid  [`NUM_MICS];
  lag_idx_t lag_idx    [`NUM_MICS];
  sample_t  lag_sample [`NUM_MICS];
  // Per baseline
  acc_t     rd_data    [`NUM_BASELINES];
  logic     pass_done  [`NUM_BASELINES];
  logic     period_first;
  lag_idx_t rd_addr;

  // Shared strobe keeps all decimators and histories in lockstep
  for (genvar m = 0; m < `NUM_MICS; m++) begin : g_mic
    cic_decimator #(
      .DECIM_RATIO (`DECIM)
    ) cic_i (
      .clk_in         (clk_in),
      .i_rst          (i_rst),
      .i_pdm_valid    (i_pdm_valid),
      .i_pdm_bit      (i_pdm_bits[m]),
      .o_sample_valid (dec_valid[m]),
      .o_sample       (dec_sample[m])
    );

    sample_history hist_i (
      .clk_in         (clk_in),
      .i_rst          (i_rst),
      .i_sample_valid (dec_valid[m]),
      .i_sample       (dec_sample[m]),
      .o_cur_sample   (cur_sample[m]),
      .o_lag_valid    (lag_valid[m]),
      .o_lag_idx      (lag_idx[m]),
      .o_lag_sample   (lag_sample[m])
    );
  end

  // Pairs i<j, numbered with i first, then j
  for (genvar i = 0; i < `NUM_MICS - 1; i++) begin : g_first
    for (genvar j = i + 1; j < `NUM_MICS; j++) begin : g_second
      localparam int BL = i * (2 * `NUM_MICS - i - 1) / 2 + (j - i - 1);

      lag_correlator corr_i (
        .clk_in         (clk_in),
        .i_rst          (i_rst),
        .i_cur_sample   (cur_sample[i]),
        .i_lag_valid    (lag_valid[j]),
        .i_lag_idx      (lag_idx[j]),
        .i_lag_sample   (lag_sample[j]),
        .i_period_first (period_first),
        .i_rd_addr      (rd_addr),
        .o_rd_data      (rd_data[BL]),
        .o_pass_done    (pass_done[BL])
      );
    end
  end

  // Baselines run together, baseline 0 paces the period
  integration_ctrl ctrl_i (
    .clk_in         (clk_in),
    .i_rst          (i_rst),
    .i_pass_done    (pass_done[0]),
    .i_rd_data_all  (rd_data),
    .o_period_first (period_first),
    .o_rd_addr      (rd_addr),
    .o_acc_valid    (o_acc_valid),
    .o_acc_bl       (o_acc_bl),
    .o_acc_lag      (o_acc_lag),
    .o_acc_data     (o_acc_data),
    .o_acc_last     (o_acc_last)
  );

endmodule

//--- integration_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Integration period counter and accumulator export walk
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "corr_config.svh"

module integration_ctrl
  import corr_pkg::*;
(
  input  logic     clk_in,
  input  logic     i_rst,
  input  logic     i_pass_done,
  input  acc_t     i_rd_data_all [`NUM_BASELINES],
  output logic     o_period_first,
  output lag_idx_t o_rd_addr,
  output logic     o_acc_valid,
  output bl_idx_t  o_acc_bl,
  output lag_idx_t o_acc_lag,
  output acc_t     o_acc_data,
  output logic     o_acc_last
);

  localparam int PER_W = (`INTEG_SAMPLES > 1) ? $clog2(`INTEG_SAMPLES) : 1;
  localparam logic [PER_W-1:0] LAST_PASS = PER_W'(`INTEG_SAMPLES - 1);
  localparam lag_idx_t LAST_LAG = lag_idx_t'(`NUM_LAGS - 1);
  localparam bl_idx_t  LAST_BL  = bl_idx_t'(`NUM_BASELINES - 1);

  logic [PER_W-1:0] pass_cnt;
  logic             walk_active;
  bl_idx_t          walk_bl;
  lag_idx_t         walk_lag;
  logic             walk_start;
  logic             walk_issue;
  logic             walk_last;

  // Last pass of the period kicks off the export
  assign walk_start     = i_pass_done && (pass_cnt == LAST_PASS);
  // Word 0 is read on the start edge itself, address is already zero
  assign walk_issue     = walk_start || walk_active;
  assign walk_last      = (walk_bl == LAST_BL) && (walk_lag == LAST_LAG);
  assign o_period_first = (pass_cnt == '0);
  assign o_rd_addr      = walk_lag;
  // Read data of the baseline issued a cycle earlier
  assign o_acc_data     = i_rd_data_all[o_acc_bl];

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      pass_cnt    <= '0;
      walk_active <= 1'b0;
      walk_bl     <= '0;
      walk_lag    <= '0;
      o_acc_valid <= 1'b0;
      o_acc_last  <= 1'b0;
      o_acc_bl    <= '0;
      o_acc_lag   <= '0;
    end else begin
      if (i_pass_done) begin
        pass_cnt <= (pass_cnt == LAST_PASS) ? '0 : pass_cnt + 1'b1;
      end
      // Index delayed by one to match the RAM read latency
      o_acc_valid <= walk_issue;
      o_acc_last  <= walk_issue && walk_last;
      if (walk_issue) begin
        o_acc_bl    <= walk_bl;
        o_acc_lag   <= walk_lag;
        walk_active <= !walk_last;
        // Baseline-major, lag-minor
        if (walk_lag == LAST_LAG) begin
          walk_lag <= '0;
          walk_bl  <= walk_last ? '0 : walk_bl + 1'b1;
        end else begin
          walk_lag <= walk_lag + 1'b1;
        end
      end
    end
  end

  // Export must finish before the correlators run the next pass
  a_no_pass_in_export: assert property (@(posedge clk_in) disable iff (i_rst)
    (walk_active || o_acc_valid) |-> !i_pass_done);

endmodule

//--- lag_correlator.sv
////////////////////////////////////////////////////////////////////////////
// Multiply-accumulate over all lags of one baseline, with export read port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "corr_config.svh"

module lag_correlator
  import corr_pkg::*;
(
  input  logic     clk_in,
  input  logic     i_rst,
  // Current sample of the first microphone
  input  sample_t  i_cur_sample,
  // Lag stream of the second microphone
  input  logic     i_lag_valid,
  input  lag_idx_t i_lag_idx,
  input  sample_t  i_lag_sample,
  // High during the first pass of an integration period
  input  logic     i_period_first,
  // Export read address, used outside a pass
  input  lag_idx_t i_rd_addr,
  output acc_t     o_rd_data,
  output logic     o_pass_done
);

  localparam lag_idx_t LAST_LAG = lag_idx_t'(`NUM_LAGS - 1);

  // Stage 1, product and the lag it belongs to
  logic     mac_valid;
  logic     mac_first;
  lag_idx_t mac_idx;
  acc_t     mac_prod;
  // Stage 2, write-back of the updated accumulator
  logic     wb_we;
  lag_idx_t wb_addr;
  acc_t     wb_data;
  lag_idx_t ram_raddr;

  // Beats fetch their accumulator, otherwise the export walk reads
  assign ram_raddr = i_lag_valid ? i_lag_idx : i_rd_addr;

  lag_ram #(
    .word_t (acc_t),
    .DEPTH  (`NUM_LAGS)
  ) acc_ram_i (
    .clk_in  (clk_in),
    .i_we    (wb_we),
    .i_waddr (wb_addr),
    .i_wdata (wb_data),
    .i_raddr (ram_raddr),
    .o_rdata (o_rd_data)
  );

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      mac_valid   <= 1'b0;
      mac_first   <= 1'b0;
      mac_idx     <= '0;
      wb_we       <= 1'b0;
      wb_addr     <= '0;
      o_pass_done <= 1'b0;
    end else begin
      mac_valid <= i_lag_valid;
      mac_first <= i_period_first;
      mac_idx   <= i_lag_idx;
      // Lag index delayed to the write-back stage
      wb_we     <= mac_valid;
      wb_addr   <= mac_idx;
      // Coincides with the write of the last lag
      o_pass_done <= mac_valid && (mac_idx == LAST_LAG);
    end
  end

  always_ff @(posedge clk_in) begin
    mac_prod <= acc_t'(i_cur_sample) * acc_t'(i_lag_sample);
    // Accumulator read on the beat is valid here
    // First pass of a period drops the old sum
    wb_data  <= mac_first ? mac_prod : o_rd_data + mac_prod;
  end

endmodule

//--- lag_ram.sv
////////////////////////////////////////////////////////////////////////////
// Simple dual-port RAM, one write port and one registered read port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module lag_ram #(
  parameter type word_t = logic [31:0],
  parameter int  DEPTH  = 8
) (
  input  logic                     clk_in,
  input  logic                     i_we,
  input  logic [$clog2(DEPTH)-1:0] i_waddr,
  input  word_t                    i_wdata,
  input  logic [$clog2(DEPTH)-1:0] i_raddr,
  output word_t                    o_rdata
);

  // Sample slots or lag accumulators, depending on word_t
  word_t mem [DEPTH];

  always_ff @(posedge clk_in) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Read data one cycle after the address
  // A read of the word being written returns the old word
  always_ff @(posedge clk_in) begin
    o_rdata <= mem[i_raddr];
  end

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status tells pass or fail
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_correlator -f all.f -o tb_correlator &&
./obj_dir/tb_correlator ||
{ echo "Build or run returned an error"; exit 1; }

//--- sample_history.sv
////////////////////////////////////////////////////////////////////////////
// Sample ring buffer for one microphone, streams lags 0..NUM_LAGS-1
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "corr_config.svh"

module sample_history
  import corr_pkg::*;
(
  input  logic     clk_in,
  input  logic     i_rst,
  input  logic     i_sample_valid,
  input  sample_t  i_sample,
  output sample_t  o_cur_sample,
  output logic     o_lag_valid,
  output lag_idx_t o_lag_idx,
  output sample_t  o_lag_sample
);

  localparam int       FILL_W   = $clog2(`NUM_LAGS + 1);
  localparam lag_idx_t LAST_LAG = lag_idx_t'(`NUM_LAGS - 1);

  lag_idx_t          wr_ptr;
  lag_idx_t          rd_addr;
  lag_idx_t          pass_cnt;
  logic              pass_active;
  // Samples stored since reset, saturates at NUM_LAGS
  logic [FILL_W-1:0] fill_cnt;
  logic              lag_empty;
  sample_t           ram_rdata;

  // Newest sample sits one slot below the write pointer
  assign rd_addr = wr_ptr - lag_idx_t'(1) - pass_cnt;

  lag_ram #(
    .word_t (sample_t),
    .DEPTH  (`NUM_LAGS)
  ) hist_ram_i (
    .clk_in  (clk_in),
    .i_we    (i_sample_valid),
    .i_waddr (wr_ptr),
    .i_wdata (i_sample),
    .i_raddr (rd_addr),
    .o_rdata (ram_rdata)
  );

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      wr_ptr      <= '0;
      pass_cnt    <= '0;
      pass_active <= 1'b0;
      fill_cnt    <= '0;
      o_lag_valid <= 1'b0;
      o_lag_idx   <= '0;
      lag_empty   <= 1'b0;
    end else begin
      // Stream flags line up with the one-cycle RAM read
      o_lag_valid <= pass_active;
      o_lag_idx   <= pass_cnt;
      lag_empty   <= FILL_W'(pass_cnt) >= fill_cnt;
      if (i_sample_valid) begin
        wr_ptr      <= wr_ptr + 1'b1;
        pass_active <= 1'b1;
        pass_cnt    <= '0;
        if (fill_cnt != FILL_W'(`NUM_LAGS)) begin
          fill_cnt <= fill_cnt + 1'b1;
        end
      end else if (pass_active) begin
        pass_active <= (pass_cnt != LAST_LAG);
        pass_cnt    <= pass_cnt + 1'b1;
      end
    end
  end

  // Held for the whole pass
  always_ff @(posedge clk_in) begin
    if (i_sample_valid) begin
      o_cur_sample <= i_sample;
    end
  end

  // Lags older than the stored history read as zero
  assign o_lag_sample = lag_empty ? '0 : ram_rdata;

  // Next sample only after the previous pass has drained
  a_no_overlap: assert property (@(posedge clk_in) disable iff (i_rst)
    i_sample_valid |-> !pass_active && !o_lag_valid);

endmodule

//--- tb_correlator.sv
////////////////////////////////////////////////////////////////////////////
// Lag correlator testbench with seeded PDM stimulus, reference model of
// CIC, sample history and per-lag correlation, export checks and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "corr_config.svh"

module tb_correlator
  import corr_pkg::*;
();

  localparam int CLK_PERIOD       = 20;
  localparam int RESET_CYCLES     = 16;
  localparam int NUM_PERIODS      = 6;
  // Leading periods with every PDM bit at 1, the rest random
  localparam int ONES_PERIODS     = 2;
  localparam int STROBES_PER_PER  = `INTEG_SAMPLES * `DECIM;
  localparam int NUM_STROBES      = NUM_PERIODS * STROBES_PER_PER;
  localparam int WORDS_PER_PERIOD = `NUM_BASELINES * `NUM_LAGS;
  localparam int TOTAL_WORDS      = NUM_PERIODS * WORDS_PER_PERIOD;
  // Strobes average about 6 cycles, with half again as margin
  localparam int WATCHDOG_CYCLES  = RESET_CYCLES + NUM_STROBES * 6 * 3 / 2;

  typedef logic [`NUM_MICS-1:0]     mic_bits_t;
  typedef logic signed [`CIC_W-1:0] cic_t;

  logic      clk_in;
  logic      i_rst;
  logic      i_pdm_valid;
  mic_bits_t i_pdm_bits;
  logic      o_acc_valid;
  bl_idx_t   o_acc_bl;
  lag_idx_t  o_acc_lag;
  acc_t      o_acc_data;
  logic      o_acc_last;

  // Reference model state
  cic_t    m_integ     [`NUM_MICS][5];
  cic_t    m_comb_prev [`NUM_MICS][5];
  // Index 0 holds the newest sample
  sample_t m_hist      [`NUM_MICS][`NUM_LAGS];
  acc_t    m_acc       [`NUM_BASELINES][`NUM_LAGS];
  int      m_strobe_cnt;
  int      m_fill;
  int      m_samples;

  // Expected export words, oldest first
  int   exp_bl_q[$];
  int   exp_lag_q[$];
  acc_t exp_data_q[$];
  bit   exp_last_q[$];

  int words_seen;
  bit in_export;

  correlator_top correlator_top_i (
    .clk_in      (clk_in),
    .i_rst       (i_rst),
    .i_pdm_valid (i_pdm_valid),
    .i_pdm_bits  (i_pdm_bits),
    .o_acc_valid (o_acc_valid),
    .o_acc_bl    (o_acc_bl),
    .o_acc_lag   (o_acc_lag),
    .o_acc_data  (o_acc_data),
    .o_acc_last  (o_acc_last)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Queue one period of expected words and restart the sums
  task automatic push_period();
    for (int bl = 0; bl < `NUM_BASELINES; bl++) begin
      for (int k = 0; k < `NUM_LAGS; k++) begin
        exp_bl_q.push_back(bl);
        exp_lag_q.push_back(k);
        exp_data_q.push_back(m_acc[bl][k]);
        exp_last_q.push_back((bl == `NUM_BASELINES - 1) && (k == `NUM_LAGS - 1));
        m_acc[bl][k] = '0;
      end
    end
  endtask

  task automatic model_strobe(input mic_bits_t bits);
    cic_t    v;
    cic_t    d;
    sample_t lag_val;
    int      bl;
    m_strobe_cnt++;
    for (int m = 0; m < `NUM_MICS; m++) begin
      // A one counts +1, a zero -1, stages taken in order
      m_integ[m][0] = m_integ[m][0] + (bits[m] ? cic_t'(1) : cic_t'(-1));
      for (int s = 1; s < 5; s++) begin
        m_integ[m][s] = m_integ[m][s] + m_integ[m][s-1];
      end
    end
    if (m_strobe_cnt == `DECIM) begin
      m_strobe_cnt = 0;
      for (int m = 0; m < `NUM_MICS; m++) begin
        // Comb chain on the decimated integrator output
        v = m_integ[m][4];
        for (int c = 0; c < 5; c++) begin
          d = v - m_comb_prev[m][c];
          m_comb_prev[m][c] = v;
          v = d;
        end
        for (int k = `NUM_LAGS - 1; k > 0; k--) begin
          m_hist[m][k] = m_hist[m][k-1];
        end
        m_hist[m][0] = sample_t'(v >>> `CIC_SHIFT);
      end
      if (m_fill < `NUM_LAGS) begin
        m_fill++;
      end
      // Pairs i<j in the order (0,1), (0,2), (1,2)
      bl = 0;
      for (int i = 0; i < `NUM_MICS - 1; i++) begin
        for (int j = i + 1; j < `NUM_MICS; j++) begin
          for (int k = 0; k < `NUM_LAGS; k++) begin
            lag_val = (k < m_fill) ? m_hist[j][k] : '0;
            m_acc[bl][k] = m_acc[bl][k] + acc_t'(m_hist[i][0]) * acc_t'(lag_val);
          end
          bl++;
        end
      end
      m_samples++;
      if (m_samples == `INTEG_SAMPLES) begin
        push_period();
        m_samples = 0;
      end
    end
  endtask

  // One strobe, then 3 to 6 idle cycles
  task automatic send_strobe(input mic_bits_t bits);
    int idle;
    idle = $urandom_range(6, 3);
    @(negedge clk_in);
    i_pdm_valid = 1'b1;
    i_pdm_bits  = bits;
    model_strobe(bits);
    @(negedge clk_in);
    i_pdm_valid = 1'b0;
    repeat (idle - 1) @(negedge clk_in);
  endtask

  task automatic check_word();
    int   bl;
    int   lag;
    acc_t data;
    bit   last;
    assert (exp_data_q.size() > 0) else
      stop_on_error($sformatf("[FAIL] %0t: export word with no completed period", $time));
    bl   = exp_bl_q.pop_front();
    lag  = exp_lag_q.pop_front();
    data = exp_data_q.pop_front();
    last = exp_last_q.pop_front();
    assert (o_acc_bl == bl_idx_t'(bl) && o_acc_lag == lag_idx_t'(lag)) else
      stop_on_error($sformatf("[FAIL] %0t: got baseline %0d lag %0d, expected %0d lag %0d",
                              $time, o_acc_bl, o_acc_lag, bl, lag));
    assert (o_acc_data == data) else
      stop_on_error($sformatf("[FAIL] %0t: baseline %0d lag %0d data %0d, expected %0d",
                              $time, bl, lag, o_acc_data, data));
    assert (o_acc_last == last) else
      stop_on_error($sformatf("[FAIL] %0t: last flag %0b on baseline %0d lag %0d",
                              $time, o_acc_last, bl, lag));
    words_seen++;
    in_export = !last;
  endtask

  // Outputs are registered, stable on the falling edge
  always @(negedge clk_in) begin
    if (!i_rst) begin
      if (o_acc_valid) begin
        check_word();
      end else begin
        assert (!in_export) else
          stop_on_error($sformatf("[FAIL] %0t: export stream broke off before its last word",
                                  $time));
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error($sformatf("Timeout at %0t: only %0d of %0d export words arrived",
                            $time, words_seen, TOTAL_WORDS));
  end

  initial begin
    void'($urandom(23));
    i_rst       = 1'b1;
    i_pdm_valid = 1'b0;
    i_pdm_bits  = '0;
    for (int m = 0; m < `NUM_MICS; m++) begin
      for (int s = 0; s < 5; s++) begin
        m_integ[m][s]     = '0;
        m_comb_prev[m][s] = '0;
      end
      for (int k = 0; k < `NUM_LAGS; k++) begin
        m_hist[m][k] = '0;
      end
    end
    for (int bl = 0; bl < `NUM_BASELINES; bl++) begin
      for (int k = 0; k < `NUM_LAGS; k++) begin
        m_acc[bl][k] = '0;
      end
    end
    m_strobe_cnt = 0;
    m_fill       = 0;
    m_samples    = 0;
    words_seen   = 0;
    in_export    = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_in);
    i_rst = 1'b0;
    // Constant input first, history still filling
    for (int s = 0; s < NUM_STROBES; s++) begin
      if (s < ONES_PERIODS * STROBES_PER_PER) begin
        send_strobe('1);
      end else begin
        send_strobe(mic_bits_t'($urandom));
      end
    end
    wait (words_seen == TOTAL_WORDS);
    // Room for a stray word after the final export
    repeat (4 * `NUM_LAGS) @(negedge clk_in);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
